/* design/zmem_pkg.sv */
// shared constants of the memory paging unit
// port decode values, window count, stall length, clock divide and reset values
// modules refer to these by scoped name, e.g. zmem_pkg::page_rst
`default_nettype none

package zmem_pkg;

	// four 16k windows over the z80 address space
	localparam int num_windows = 4;

	// low address byte shared by all ATM ports (xFF7, x7F7) and EFF7
	localparam logic [7:0] port_atm_lo = 8'hF7;

	// 7FFD decode pattern
	// bit 7 is compared with a15 and bit 1 with a1, other bits unused
	localparam logic [7:0] port_7ffd_a = 8'h7D;

	// high byte of the EFF7 port
	localparam logic [7:0] port_eff7_hi = 8'hEF;

	// low byte of the pager readback port xxBE
	localparam logic [7:0] port_rdbk_lo = 8'hBE;

	// a13..a8 of a DOS entry point (3Dxx)
	localparam logic [5:0] dos_entry_hi = 6'h3D;

	// extra fclk cycles of z80 clock stall after the DOS turn-on cycle
	localparam logic [2:0] stall_len = 3'd3;

	// fclk cycles per z80 clock period
	localparam int zclk_div = 4;

	// stored (inverted) page after reset, so window shows page FF
	localparam logic [7:0] page_rst = 8'h00;

	// 7FFD and EFF7 contents after reset
	localparam logic [7:0] p7ffd_rst = 8'h00;
	localparam logic [7:0] peff7_rst = 8'h00; // bit 2 low, 1M addressing on

	// DOS is active out of reset
	localparam logic dos_rst = 1'b1;

endpackage

`default_nettype wire

/* design/zclock_gen.sv */
// z80 clock generator
// divides fclk by zmem_pkg::zclk_div and gives one-fclk zpos/zneg strobes
// just before the z80 clock rises or falls
// zclk_stall freezes the phase, so zclk holds its level and no new strobe appears
`timescale 1ns/1ps
`default_nettype none

module zclock_gen (
	input  wire fclk,
	input  wire rst_n,
	input  wire zclk_stall, // from the pagers, DOS turn-on
	output logic zclk,
	output wire zpos,
	output wire zneg
);

	localparam logic [1:0] ph_last = 2'(zmem_pkg::zclk_div - 1);     // zpos phase
	localparam logic [1:0] ph_half = 2'(zmem_pkg::zclk_div / 2 - 1); // zneg phase

	logic [1:0] phase;
	logic       fresh; // phase counter moved on the last edge

	// phase counter, paused while stalled
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			phase <= 2'd0;
			fresh <= 1'b0;
		end
		else
		begin
			if (!zclk_stall)
				phase <= (phase == ph_last) ? 2'd0 : phase + 2'd1;
			fresh <= ~zclk_stall; // held phase must not repeat its strobe
		end
	end

	// strobe only on the first cycle of a phase
	// the zneg that starts a stall is the one that turned DOS on
	assign zpos = fresh & (phase == ph_last);
	assign zneg = fresh & (phase == ph_half);

	// the z80 clock itself follows the strobes
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			zclk <= 1'b0;
		else if (zpos)
			zclk <= 1'b1;
		else if (zneg)
			zclk <= 1'b0;
	end

endmodule

`default_nettype wire

/* design/zports.sv */
// z80 i/o port decoder for the paging unit
// catches the start of each i/o write on zneg, holds 7FFD, EFF7 and the DOS flag,
// and gives a one-fclk strobe for writes to the ATM xFF7/x7F7 ports
// the pagers latch their own maps off atm_f7_wr
`timescale 1ns/1ps
`default_nettype none

module zports (
	input  wire        fclk,
	input  wire        rst_n,
	input  wire        zneg,
	input  wire [15:0] za,
	input  wire [ 7:0] zd_in,
	input  wire        iorq_n,
	input  wire        wr_n,
	input  wire        dos_turn_on,  // ORed over all windows
	input  wire        dos_turn_off,
	output wire        atm_f7_wr,
	output wire [ 5:0] pent1m_page,
	output wire        pent1m_rom,
	output wire        pent1m_ram0_0,
	output wire        pent1m_1m_on,
	output wire        dos
);

	logic       iorq_n_r, wr_n_r; // bus state at the previous zneg
	logic       io_wr_stb;        // first zneg of an i/o write
	logic       sel_7ffd, sel_eff7, sel_atm;
	logic [7:0] p7ffd;
	logic [7:0] peff7;
	logic       dos_r;

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			iorq_n_r <= 1'b1;
			wr_n_r   <= 1'b1;
		end
		else if (zneg)
		begin
			iorq_n_r <= iorq_n;
			wr_n_r   <= wr_n;
		end
	end

	// both strobes low now, not both low at the previous zneg
	assign io_wr_stb = zneg & ~iorq_n & ~wr_n & (iorq_n_r | wr_n_r);

	// 7FFD is decoded on a15 and a1 only, as on the pentagon
	assign sel_7ffd = (za[15] == zmem_pkg::port_7ffd_a[7]) &&
	                  (za[1] == zmem_pkg::port_7ffd_a[1]);
	assign sel_eff7 = (za[15:8] == zmem_pkg::port_eff7_hi) &&
	                  (za[7:0] == zmem_pkg::port_atm_lo);
	// xFF7 and x7F7 have a13:a12 = 11, which keeps EFF7 out
	assign sel_atm  = (za[7:0] == zmem_pkg::port_atm_lo) && (za[13:12] == 2'b11);

	assign atm_f7_wr = io_wr_stb & sel_atm;

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			p7ffd <= zmem_pkg::p7ffd_rst;
			peff7 <= zmem_pkg::peff7_rst;
		end
		else if (io_wr_stb)
		begin
			if (sel_7ffd)
				p7ffd <= zd_in;
			if (sel_eff7)
				peff7 <= zd_in;
		end
	end

	assign pent1m_page   = {p7ffd[7:5], p7ffd[2:0]}; // 1M page, d7..d5 on top
	assign pent1m_rom    = p7ffd[4];                 // map select
	assign pent1m_ram0_0 = peff7[3];                 // ram page 0 at 0000
	assign pent1m_1m_on  = ~peff7[2];                // low bit means 1M on

	// DOS flag, turn-on wins if both come in one cycle
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			dos_r <= zmem_pkg::dos_rst;
		else if (dos_turn_on)
			dos_r <= 1'b1;
		else if (dos_turn_off)
			dos_r <= 1'b0;
	end

	assign dos = dos_r;

endmodule

`default_nettype wire

/* design/atm_pager.sv */
// ATM style pager for one 16k window (addr = window number 0..3)
// keeps two maps picked by 7FFD bit 4; each map has the page as the cpu wrote it
// (inverted), a ram/rom bit and a 7FFD-override bit
// also flags DOS entry from 3Dxx and execution from ram, and stretches the
// z80 clock for a few fclk after DOS turns on
`timescale 1ns/1ps
`default_nettype none

module atm_pager #(
	parameter int unsigned addr = 0
) (
	input  wire        fclk,
	input  wire        rst_n,
	input  wire        zpos,
	input  wire        zneg,
	input  wire [15:0] za,
	input  wire [ 7:0] zd_in,
	input  wire        mreq_n,
	input  wire        m1_n,
	input  wire        pager_off,     // service rom in every window
	input  wire        pent1m_rom,
	input  wire [ 5:0] pent1m_page,
	input  wire        pent1m_ram0_0,
	input  wire        pent1m_1m_on,
	input  wire        in_nmi,        // above ram0_0 in window 0
	input  wire        atm_f7_wr,
	input  wire        dos,
	output logic [7:0] page,          // physical page
	output logic       romnram,       // 1 = rom
	output wire        dos_turn_on,
	output wire        dos_turn_off,
	output wire        stall_req,
	output wire  [7:0] rd_page0,      // readback, stored form
	output wire  [7:0] rd_page1,
	output wire  [1:0] rd_dos7ffd,
	output wire  [1:0] rd_ramnrom
);

	localparam logic [1:0] win = addr[1:0];

	logic [1:0][7:0] pages;    // inverted pages, one per map
	logic [1:0]      ramnrom;  // 1 = ram
	logic [1:0]      dos_7ffd; // ram: 7FFD low bits, rom: bit 0 from dos
	logic [7:0]      cur;      // stored page of the active map
	logic            m1_n_r, mreq_n_r;
	logic            fetch_stb; // opcode fetch starts in this window
	logic [2:0]      stall_cnt;

	assign cur = pages[pent1m_rom];

	// map writes through xFF7 / x7F7 of this window
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pages    <= {2{zmem_pkg::page_rst}};
			ramnrom  <= 2'b00;
			dos_7ffd <= 2'b00;
		end
		else if (atm_f7_wr && (za[15:14] == win))
		begin
			if (za[11])
			begin // xFF7, 6 bit page plus flags
				pages[pent1m_rom]    <= {2'b11, zd_in[5:0]};
				ramnrom[pent1m_rom]  <= zd_in[6];
				dos_7ffd[pent1m_rom] <= zd_in[7];
			end
			else
			begin // x7F7, full ram page, override bit kept
				pages[pent1m_rom]   <= zd_in;
				ramnrom[pent1m_rom] <= 1'b1;
			end
		end
	end

	// physical page, one fclk behind its inputs
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			page    <= ~zmem_pkg::page_rst;
			romnram <= 1'b1;
		end
		else if (pager_off)
		begin
			page    <= 8'hFF;
			romnram <= 1'b1;
		end
		else if ((win == 2'd0) && in_nmi)
		begin // nmi handler lives in the last ram page
			page    <= 8'hFF;
			romnram <= 1'b0;
		end
		else if ((win == 2'd0) && pent1m_ram0_0)
		begin
			page    <= 8'h00;
			romnram <= 1'b0;
		end
		else
		begin
			romnram <= ~ramnrom[pent1m_rom];
			if (!dos_7ffd[pent1m_rom])
				page <= ~cur;
			else if (!ramnrom[pent1m_rom])
				page <= {~cur[7:1], dos}; // rom pair switched by DOS
			else if (pent1m_1m_on)
				page <= {~cur[7:6], pent1m_page};
			else
				page <= {~cur[7:3], pent1m_page[2:0]}; // 128k mode
		end
	end

	assign rd_page0   = pages[0];
	assign rd_page1   = pages[1];
	assign rd_dos7ffd = dos_7ffd;
	assign rd_ramnrom = ramnrom;

	// m1 sampled on zpos, mreq on zneg
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			m1_n_r   <= 1'b1;
			mreq_n_r <= 1'b1;
		end
		else
		begin
			if (zpos)
				m1_n_r <= m1_n;
			if (zneg)
				mreq_n_r <= mreq_n;
		end
	end

	assign fetch_stb = zneg & (za[15:14] == win) & ~m1_n_r & ~mreq_n & mreq_n_r;

	// DOS rom lives in map 1 with the override bit set
	assign dos_turn_on  = fetch_stb & (za[13:8] == zmem_pkg::dos_entry_hi) &
	                      dos_7ffd[1] & ~ramnrom[1] & pent1m_rom;
	assign dos_turn_off = fetch_stb & ramnrom[pent1m_rom];

	// stall for the turn-on cycle plus stall_len more, the rom needs time after
	// its page flips
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			stall_cnt <= 3'd0;
		else if (dos_turn_on)
			stall_cnt <= zmem_pkg::stall_len;
		else if (stall_cnt != 3'd0)
			stall_cnt <= stall_cnt - 3'd1;
	end

	assign stall_req = dos_turn_on | (stall_cnt != 3'd0);

endmodule

`default_nettype wire

/* design/window_mux.sv */
// picks the active window by a15:a14 and builds the 22 bit physical address
// ORs the DOS strobes and stall requests of all windows
// answers i/o reads of xxBE with the addressed window's stored map
`timescale 1ns/1ps
`default_nettype none

module window_mux (
	input  wire [15:0] za,
	input  wire        iorq_n,
	input  wire        rd_n,
	input  wire [zmem_pkg::num_windows-1:0][7:0] win_page,
	input  wire [zmem_pkg::num_windows-1:0]      win_romnram,
	input  wire [zmem_pkg::num_windows-1:0]      win_dos_on,
	input  wire [zmem_pkg::num_windows-1:0]      win_dos_off,
	input  wire [zmem_pkg::num_windows-1:0]      win_stall,
	input  wire [zmem_pkg::num_windows-1:0][7:0] win_rd_page0,
	input  wire [zmem_pkg::num_windows-1:0][7:0] win_rd_page1,
	input  wire [zmem_pkg::num_windows-1:0][1:0] win_rd_dos7ffd,
	input  wire [zmem_pkg::num_windows-1:0][1:0] win_rd_ramnrom,
	output wire [21:0] mem_addr,
	output wire        romnram,
	output wire        dos_turn_on,
	output wire        dos_turn_off,
	output wire        zclk_stall,
	output logic [7:0] zd_out,
	output wire        zd_out_en
);

	wire [1:0] sel = za[15:14]; // window of the current address

	assign mem_addr = {win_page[sel], za[13:0]};
	assign romnram  = win_romnram[sel];

	// only the fetching window can strobe, but OR keeps it simple
	assign dos_turn_on  = |win_dos_on;
	assign dos_turn_off = |win_dos_off;
	assign zclk_stall   = |win_stall;

	assign zd_out_en = ~iorq_n & ~rd_n & (za[7:0] == zmem_pkg::port_rdbk_lo);

	// readback layout for a9 set: d3:d2 override bits, d1:d0 ram bits (map 1 high)
	always_comb
	begin
		if (za[9])
			zd_out = {4'h0, win_rd_dos7ffd[sel], win_rd_ramnrom[sel]};
		else if (za[8])
			zd_out = win_rd_page1[sel];
		else
			zd_out = win_rd_page0[sel];
	end

endmodule

`default_nettype wire

/* design/mem_pager_top.sv */
// memory paging unit top level
// z80 bus in, 22 bit physical address and rom/ram select out
// clock generator, port decoder, one pager per 16k window and the window mux
`timescale 1ns/1ps
`default_nettype none

module mem_pager_top (
	input  wire        fclk,
	input  wire        rst_n,
	input  wire [15:0] za,
	input  wire [ 7:0] zd_in,
	input  wire        mreq_n,
	input  wire        iorq_n,
	input  wire        rd_n,
	input  wire        wr_n,
	input  wire        m1_n,
	input  wire        in_nmi,
	input  wire        pager_off,
	output wire [21:0] mem_addr,
	output wire        romnram,
	output wire        dos,
	output wire        zclk_stall,
	output wire        zclk,
	output wire        zpos,
	output wire        zneg,
	output wire [ 7:0] zd_out,
	output wire        zd_out_en
);

	localparam int nw = zmem_pkg::num_windows;

	logic            atm_f7_wr;
	logic [5:0]      pent1m_page;
	logic            pent1m_rom, pent1m_ram0_0, pent1m_1m_on;
	logic            dos_turn_on, dos_turn_off;
	logic [nw-1:0][7:0] w_page, w_rd_page0, w_rd_page1; // per window
	logic [nw-1:0]      w_romnram, w_dos_on, w_dos_off, w_stall;
	logic [nw-1:0][1:0] w_rd_dos7ffd, w_rd_ramnrom;

	zclock_gen i_clk (
		.fclk(fclk), .rst_n(rst_n), .zclk_stall(zclk_stall),
		.zclk(zclk), .zpos(zpos), .zneg(zneg)
	);

	zports i_ports (
		.fclk(fclk), .rst_n(rst_n), .zneg(zneg), .za(za), .zd_in(zd_in),
		.iorq_n(iorq_n), .wr_n(wr_n),
		.dos_turn_on(dos_turn_on), .dos_turn_off(dos_turn_off),
		.atm_f7_wr(atm_f7_wr), .pent1m_page(pent1m_page), .pent1m_rom(pent1m_rom),
		.pent1m_ram0_0(pent1m_ram0_0), .pent1m_1m_on(pent1m_1m_on), .dos(dos)
	);

	for (genvar w = 0; w < nw; w++)
	begin : g_win
		atm_pager #(.addr(w)) i_pager (
			.fclk(fclk), .rst_n(rst_n), .zpos(zpos), .zneg(zneg),
			.za(za), .zd_in(zd_in), .mreq_n(mreq_n), .m1_n(m1_n),
			.pager_off(pager_off), .pent1m_rom(pent1m_rom), .pent1m_page(pent1m_page),
			.pent1m_ram0_0(pent1m_ram0_0), .pent1m_1m_on(pent1m_1m_on),
			.in_nmi(in_nmi), .atm_f7_wr(atm_f7_wr), .dos(dos),
			.page(w_page[w]), .romnram(w_romnram[w]),
			.dos_turn_on(w_dos_on[w]), .dos_turn_off(w_dos_off[w]),
			.stall_req(w_stall[w]),
			.rd_page0(w_rd_page0[w]), .rd_page1(w_rd_page1[w]),
			.rd_dos7ffd(w_rd_dos7ffd[w]), .rd_ramnrom(w_rd_ramnrom[w])
		);
	end

	window_mux i_mux (
		.za(za), .iorq_n(iorq_n), .rd_n(rd_n),
		.win_page(w_page), .win_romnram(w_romnram),
		.win_dos_on(w_dos_on), .win_dos_off(w_dos_off), .win_stall(w_stall),
		.win_rd_page0(w_rd_page0), .win_rd_page1(w_rd_page1),
		.win_rd_dos7ffd(w_rd_dos7ffd), .win_rd_ramnrom(w_rd_ramnrom),
		.mem_addr(mem_addr), .romnram(romnram),
		.dos_turn_on(dos_turn_on), .dos_turn_off(dos_turn_off),
		.zclk_stall(zclk_stall), .zd_out(zd_out), .zd_out_en(zd_out_en)
	);

endmodule

`default_nettype wire

/* verif/mem_pager_props.sv */
// timing properties of the paging unit, bound into mem_pager_top
// port strobe width, DOS stall length, frozen z80 strobes, z80 clock edges,
// quiet outputs in reset
`timescale 1ns/1ps
`default_nettype none

module mem_pager_props (
	input wire fclk,
	input wire rst_n,
	input wire atm_f7_wr,
	input wire dos_turn_on,
	input wire dos_turn_off,
	input wire zclk_stall,
	input wire zclk,
	input wire zpos,
	input wire zneg,
	input wire zd_out_en
);

	int unsigned fail_cnt = 0; // failed assertions so far

	a_f7_single: assert property (@(posedge fclk) disable iff (!rst_n)
		atm_f7_wr |=> !atm_f7_wr)
	else
	begin
		$error("atm_f7_wr high for more than one fclk");
		fail_cnt++;
	end

	// turn-on cycle plus three more before release
	a_stall_len: assert property (@(posedge fclk) disable iff (!rst_n)
		dos_turn_on |-> zclk_stall ##1 zclk_stall ##1 zclk_stall ##1 zclk_stall ##1 !zclk_stall)
	else
	begin
		$error("zclk_stall not exactly 4 fclk after dos_turn_on");
		fail_cnt++;
	end

	// the zneg of the turn-on cycle itself is allowed
	a_no_strobe: assert property (@(posedge fclk) disable iff (!rst_n)
		zclk_stall && !dos_turn_on |-> !zpos && !zneg)
	else
	begin
		$error("z80 clock strobe during stall");
		fail_cnt++;
	end

	// zclk is high right after zpos and low right after zneg
	a_zclk_edge: assert property (@(posedge fclk) disable iff (!rst_n)
		zpos || zneg |=> zclk == $past(zpos))
	else
	begin
		$error("zclk did not follow the zpos or zneg strobe");
		fail_cnt++;
	end

	// held z80 clock level while stalled
	a_zclk_hold: assert property (@(posedge fclk) disable iff (!rst_n)
		zclk_stall && !dos_turn_on |=> $stable(zclk))
	else
	begin
		$error("zclk changed during stall");
		fail_cnt++;
	end

	a_reset_quiet: assert property (@(posedge fclk)
		!rst_n |-> !atm_f7_wr && !dos_turn_on && !dos_turn_off && !zclk_stall && !zd_out_en)
	else
	begin
		$error("control output active in reset");
		fail_cnt++;
	end

endmodule

`default_nettype wire

/* verif/tb_mem_pager.sv */
// testbench for the memory paging unit
// drives the z80 bus with port writes, xxBE reads and opcode fetches, keeps a model
// of the page maps and checks mem_addr, romnram, dos and readback data against it
// bus timing is checked by the bound props module
`timescale 1ns/1ps
`default_nettype none

module tb_mem_pager;

	localparam int max_cycles = 20000; // well over 80 bus ops of up to 20 fclk each

	logic        fclk;
	logic        rst_n;
	logic [15:0] za;
	logic [ 7:0] zd_in;
	logic        mreq_n, iorq_n, rd_n, wr_n, m1_n;
	logic        in_nmi, pager_off;
	wire  [21:0] mem_addr;
	wire  [ 7:0] zd_out;
	wire         romnram, dos, zclk_stall, zclk, zpos, zneg, zd_out_en;

	// model of the pager state
	logic [7:0] m_page [4][2]; // stored form as the cpu wrote it
	logic [1:0] m_ram [4];     // bit per map is 1 for ram
	logic [1:0] m_o7 [4];      // 7FFD override bit per map
	logic [7:0] m_7ffd, m_eff7;
	logic       m_dos;

	string  test_name;
	int     errors, test_err, tests_run, tests_failed, cycles;
	integer seed;

	mem_pager_top i_dut (
		.fclk(fclk), .rst_n(rst_n), .za(za), .zd_in(zd_in), .mreq_n(mreq_n),
		.iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n), .m1_n(m1_n), .in_nmi(in_nmi),
		.pager_off(pager_off), .mem_addr(mem_addr), .romnram(romnram), .dos(dos),
		.zclk_stall(zclk_stall), .zclk(zclk), .zpos(zpos), .zneg(zneg),
		.zd_out(zd_out), .zd_out_en(zd_out_en)
	);

	bind mem_pager_top mem_pager_props i_props (
		.fclk(fclk), .rst_n(rst_n), .atm_f7_wr(atm_f7_wr), .dos_turn_on(dos_turn_on),
		.dos_turn_off(dos_turn_off), .zclk_stall(zclk_stall), .zclk(zclk),
		.zpos(zpos), .zneg(zneg), .zd_out_en(zd_out_en)
	);

	initial
	begin
		fclk = 1'b0;
		forever
			#20 fclk = ~fclk; // 40 ns
	end

	always @(posedge fclk)
	begin
		cycles++;
		if (cycles >= max_cycles)
		begin
			$display("timeout after %0d fclk cycles, test %s did not finish", cycles, test_name);
			$display("TEST FAILED");
			$finish;
		end
	end

	function automatic int total_errors();
		return errors + int'(i_dut.i_props.fail_cnt); // value checks plus assertion fails
	endfunction

	// expected {romnram, page} of window w by the page rules in priority order
	function automatic logic [8:0] exp_map(input logic [1:0] w);
		logic       map;
		logic [7:0] st;
		map = m_7ffd[4];
		st = m_page[w][map];
		if (pager_off)
			return {1'b1, 8'hFF};
		if (w == 2'd0 && in_nmi)
			return {1'b0, 8'hFF};
		if (w == 2'd0 && m_eff7[3])
			return {1'b0, 8'h00};
		if (!m_o7[w][map])
			return {~m_ram[w][map], ~st};
		if (!m_ram[w][map])
			return {1'b1, ~st[7:1], m_dos}; // rom bit 0 from dos
		if (!m_eff7[2])
			return {1'b0, ~st[7:6], m_7ffd[7:5], m_7ffd[2:0]}; // 1M mode
		return {1'b0, ~st[7:3], m_7ffd[2:0]};
	endfunction

	task automatic check_val(input string what, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		assert (act_v === exp_v)
		else
		begin
			$display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp_v, act_v);
			errors++;
		end
	endtask

	task automatic step(); // inputs change 5 ns after the rising edge
		@(posedge fclk);
		#5;
	endtask

	task automatic wait_zneg();
		@(negedge fclk);
		while (!zneg)
			@(negedge fclk);
	endtask

	task automatic wait_zpos();
		@(negedge fclk);
		while (!zpos)
			@(negedge fclk);
	endtask

	task automatic io_write(input logic [15:0] a, input logic [7:0] d);
		step();
		za = a;
		zd_in = d;
		iorq_n = 1'b0;
		wr_n = 1'b0;
		wait_zneg(); // write taken here
		step();
		iorq_n = 1'b1;
		wr_n = 1'b1;
		wait_zneg(); // idle bus seen before the next write
		step();
	endtask

	task automatic set_7ffd(input logic [7:0] d);
		io_write(16'h7FFD, d);
		m_7ffd = d;
	endtask

	task automatic set_eff7(input logic [7:0] d);
		io_write(16'hEFF7, d);
		m_eff7 = d;
	endtask

	// full selects x7F7 (8 bit ram page) over xFF7 (6 bit page plus flags)
	task automatic atm_write(input logic [1:0] w, input logic full, input logic [7:0] d);
		logic map;
		map = m_7ffd[4];
		io_write({w, 2'b11, full ? 4'h7 : 4'hF, 8'hF7}, d);
		m_page[w][map] = full ? d : {2'b11, d[5:0]};
		m_ram[w][map] = full | d[6];
		if (!full)
			m_o7[w][map] = d[7];
	endtask

	task automatic mem_check(input logic [1:0] w);
		logic [15:0] a;
		logic [ 8:0] e;
		a = {w, 14'($random(seed))};
		step();
		za = a;
		mreq_n = 1'b0;
		rd_n = 1'b0;
		@(negedge fclk);
		e = exp_map(w);
		check_val("mem_addr", 32'({e[7:0], a[13:0]}), 32'(mem_addr));
		check_val("romnram", 32'(e[8]), 32'(romnram));
		step();
		mreq_n = 1'b1;
		rd_n = 1'b1;
		wait_zneg(); // mreq high registered so that a later fetch is seen
		step();
	endtask

	// sel[1] is a9 for the flag bits and sel[0] is a8 for the map 1 page
	task automatic rdbk_check(input logic [1:0] w, input logic [1:0] sel);
		logic [7:0] e;
		if (sel[1])
			e = {4'h0, m_o7[w], m_ram[w]};
		else
			e = m_page[w][sel[0]];
		step();
		za = {w, 4'h0, sel, 8'hBE};
		iorq_n = 1'b0;
		rd_n = 1'b0;
		@(negedge fclk);
		check_val("zd_out_en", 32'd1, 32'(zd_out_en));
		check_val("zd_out", 32'(e), 32'(zd_out));
		step();
		iorq_n = 1'b1;
		rd_n = 1'b1;
	endtask

	task automatic fetch(input logic [15:0] a); // opcode fetch with m1 ahead of mreq
		step();
		za = a;
		m1_n = 1'b0;
		rd_n = 1'b0;
		wait_zpos();
		step();
		mreq_n = 1'b0;
		wait_zneg(); // dos strobes come here
		step();
		m1_n = 1'b1;
		mreq_n = 1'b1;
		rd_n = 1'b1;
		wait_zpos();
		wait_zneg();
		step();
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_err = total_errors();
	endtask

	task automatic end_test();
		tests_run++;
		if (total_errors() == test_err)
			$display("test %s: ok", test_name);
		else
		begin
			tests_failed++;
			$display("test %s: %0d errors", test_name, total_errors() - test_err);
		end
	endtask

	initial
	begin
		seed = 94967;
		rst_n = 1'b0;
		za = 16'h0000;
		zd_in = 8'h00;
		mreq_n = 1'b1;
		iorq_n = 1'b1;
		rd_n = 1'b1;
		wr_n = 1'b1;
		m1_n = 1'b1;
		in_nmi = 1'b0;
		pager_off = 1'b0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		cycles = 0;
		test_name = "reset";
		for (int w = 0; w < 4; w++)
		begin
			m_page[w] = '{8'h00, 8'h00}; // reset value means page FF
			m_ram[w] = 2'b00;
			m_o7[w] = 2'b00;
		end
		m_7ffd = 8'h00;
		m_eff7 = 8'h00;
		m_dos = 1'b1;
		repeat (8) @(posedge fclk);
		#5 rst_n = 1'b1;

		begin_test("reset_and_maps");
		for (int w = 0; w < 4; w++)
			mem_check(2'(w));
		for (int map = 0; map < 2; map++)
		begin
			set_7ffd(8'(map << 4));
			for (int w = 0; w < 4; w++)
				atm_write(2'(w), 1'($random(seed)), 8'($random(seed)));
		end
		for (int map = 0; map < 2; map++)
		begin
			set_7ffd(8'(map << 4));
			for (int w = 0; w < 4; w++)
				mem_check(2'(w));
		end
		end_test();

		begin_test("7ffd_override");
		set_7ffd(8'h00);
		atm_write(2'd0, 1'b0, {2'b10, 6'($random(seed))}); // rom with override
		for (int w = 1; w < 4; w++)
			atm_write(2'(w), 1'b0, {2'b11, 6'($random(seed))}); // ram with override
		for (int mode = 0; mode < 2; mode++)
		begin
			set_eff7(mode == 0 ? 8'h04 : 8'h00); // 128k first and 1M second
			set_7ffd(8'($random(seed)) & 8'hEF);
			for (int w = 0; w < 4; w++)
				mem_check(2'(w));
		end
		end_test();

		begin_test("dos_entry");
		set_eff7(8'h00);
		set_7ffd(8'h10); // map 1
		atm_write(2'd0, 1'b0, {2'b10, 6'($random(seed))}); // DOS rom
		atm_write(2'd1, 1'b1, 8'($random(seed)));
		fetch({2'b01, 14'($random(seed))}); // execute from ram
		m_dos = 1'b0;
		check_val("dos off", 32'd0, 32'(dos));
		mem_check(2'd0);
		fetch({8'h3D, 8'($random(seed))});
		m_dos = 1'b1;
		check_val("dos on", 32'd1, 32'(dos));
		mem_check(2'd0);
		end_test();

		begin_test("pager_off_nmi");
		step();
		pager_off = 1'b1;
		for (int w = 0; w < 4; w++)
			mem_check(2'(w));
		step();
		pager_off = 1'b0;
		in_nmi = 1'b1;
		set_eff7(8'h08); // nmi wins over the ram page 0 request
		mem_check(2'd0);
		mem_check(2'd2);
		step();
		in_nmi = 1'b0;
		mem_check(2'd0);
		set_eff7(8'h00);
		end_test();

		begin_test("readback");
		for (int w = 0; w < 4; w++)
			for (int s = 0; s < 3; s++)
				rdbk_check(2'(w), 2'(s));
		end_test();

		$display("summary: %0d tests, %0d failed, %0d value errors, %0d assertion failures",
			tests_run, tests_failed, errors, i_dut.i_props.fail_cnt);
		if (total_errors() == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
design/zmem_pkg.sv
design/zclock_gen.sv
design/zports.sv
design/atm_pager.sv
design/window_mux.sv
design/mem_pager_top.sv
verif/mem_pager_props.sv
verif/tb_mem_pager.sv

/* Makefile */
# Verilator build and run of the memory paging unit testbench

SRCS := $(shell cat verilog.f)

obj_dir/Vtb_mem_pager: verilog.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_mem_pager -f verilog.f

run: obj_dir/Vtb_mem_pager
	./obj_dir/Vtb_mem_pager +verilator+error+limit+1000 > sim.log 2>&1; cat sim.log
	@if grep -q "TEST FAILED" sim.log; then exit 1; fi
	@grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
